// File: rtl/gray_pkg.sv
package gray_pkg;

    // pixel and luma widths
    localparam int PIX_W  = 10;
    localparam int LUMA_W = 11;
    // counter sized for 640x480
    localparam int CNT_W  = 20;

    // luma weights, each product shifted right before the sum
    localparam int W_RED    = 19;
    localparam int W_GREEN  = 75;
    localparam int W_BLUE   = 37;
    localparam int SH_RED   = 6;
    localparam int SH_GREEN = 7;
    localparam int SH_BLUE  = 8;

    localparam logic [LUMA_W-1:0] THRESH_RST = 11'd600;
    // pixels in a full frame, register keeps this minus one
    localparam int NPIX_RST = 640 * 480;

    // axi4-lite map
    localparam int AXI_AW = 4;
    localparam int AXI_DW = 32;
    localparam logic [AXI_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [AXI_AW-1:0] ADDR_THRESH = 4'h4;
    localparam logic [AXI_AW-1:0] ADDR_NPIX   = 4'h8;
    localparam logic [AXI_AW-1:0] ADDR_STATUS = 4'hC;
    localparam logic [1:0]        RESP_OKAY   = 2'b00;

    localparam int PIPE_DEPTH = 2;

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_STREAM, ST_DRAIN} ctrl_state_e;

endpackage

// File: rtl/gray_csr.sv
`timescale 1ns/100ps
module gray_csr (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  logic [gray_pkg::AXI_AW-1:0]   i_awaddr,
    input  logic                          i_wvalid,
    output logic                          o_wready,
    input  logic [gray_pkg::AXI_DW-1:0]   i_wdata,
    input  logic [gray_pkg::AXI_DW/8-1:0] i_wstrb,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    output logic [1:0]                    o_bresp,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    input  logic [gray_pkg::AXI_AW-1:0]   i_araddr,
    output logic                          o_rvalid,
    input  logic                          i_rready,
    output logic [gray_pkg::AXI_DW-1:0]   o_rdata,
    output logic [1:0]                    o_rresp,
    output logic                          o_start,
    output logic                          o_binarize,
    output logic [gray_pkg::LUMA_W-1:0]   o_thresh,
    output logic [gray_pkg::CNT_W-1:0]    o_npix,
    input  logic                          i_busy,
    input  logic                          i_done
);
    import gray_pkg::*;

    logic              wr_go;
    logic              rd_go;
    logic [AXI_DW-1:0] wr_ctrl;
    logic [AXI_DW-1:0] wr_thresh;
    logic [AXI_DW-1:0] wr_npix;
    logic              done_flag;

    // byte lanes with strobe set take the new data
    function automatic logic [AXI_DW-1:0] strb_merge(
        input logic [AXI_DW-1:0]   old_v,
        input logic [AXI_DW-1:0]   new_v,
        input logic [AXI_DW/8-1:0] strb
    );
        logic [AXI_DW-1:0] res;
        res = old_v;
        for (int i = 0; i < AXI_DW / 8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // aw and w taken together, only with no response pending
    assign wr_go     = i_awvalid && i_wvalid && !o_bvalid;
    assign rd_go     = i_arvalid && !o_rvalid;
    assign o_awready = wr_go;
    assign o_wready  = wr_go;
    assign o_arready = rd_go;
    assign o_bresp   = RESP_OKAY;
    assign o_rresp   = RESP_OKAY;

    // start reads back as 0, so it merges in as 0
    assign wr_ctrl   = strb_merge(AXI_DW'({o_binarize, 1'b0}), i_wdata, i_wstrb);
    assign wr_thresh = strb_merge(AXI_DW'(o_thresh), i_wdata, i_wstrb);
    assign wr_npix   = strb_merge(AXI_DW'(o_npix), i_wdata, i_wstrb);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_start    <= 1'b0;
            o_binarize <= 1'b0;
            o_thresh   <= THRESH_RST;
            o_npix     <= CNT_W'(NPIX_RST - 1);
        end else begin
            // start is a single cycle pulse
            o_start <= 1'b0;
            if (wr_go) begin
                case (i_awaddr)
                    ADDR_CTRL: begin
                        o_start    <= wr_ctrl[0];
                        o_binarize <= wr_ctrl[1];
                    end
                    ADDR_THRESH: o_thresh <= wr_thresh[LUMA_W-1:0];
                    ADDR_NPIX:   o_npix   <= wr_npix[CNT_W-1:0];
                    // status is read only, unmapped ignored
                    default: ;
                endcase
            end
        end
    end

    // sticky done, cleared by a start the controller takes
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            done_flag <= 1'b0;
        end else if (o_start && !i_busy) begin
            done_flag <= 1'b0;
        end else if (i_done) begin
            done_flag <= 1'b1;
        end
    end

    // responses hold until the master takes them
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (rd_go) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // read data latched at the address handshake
    always_ff @(posedge i_clk) begin
        if (rd_go) begin
            case (i_araddr)
                ADDR_CTRL:   o_rdata <= AXI_DW'({o_binarize, 1'b0});
                ADDR_THRESH: o_rdata <= AXI_DW'(o_thresh);
                ADDR_NPIX:   o_rdata <= AXI_DW'(o_npix);
                ADDR_STATUS: o_rdata <= AXI_DW'({done_flag, i_busy});
                default:     o_rdata <= '0;
            endcase
        end
    end

endmodule

// File: rtl/frame_ctrl.sv
`timescale 1ns/100ps
module frame_ctrl (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start,
    input  logic i_pix_valid,
    input  logic i_term,
    input  logic i_last_out,
    output logic o_cnt_clr,
    output logic o_cnt_en,
    output logic o_accept,
    output logic o_last,
    output logic o_read_req,
    output logic o_busy,
    output logic o_done
);
    import gray_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // pixels only taken while streaming, dropped otherwise
    assign o_accept   = (state == ST_STREAM) && i_pix_valid;
    assign o_cnt_en   = o_accept;
    // terminal count marks the final pixel
    assign o_last     = o_accept && i_term;
    assign o_cnt_clr  = (state == ST_IDLE) && i_start;
    // request lasts exactly the one REQ cycle
    assign o_read_req = (state == ST_REQ);
    assign o_busy     = (state != ST_IDLE);
    assign o_done     = (state == ST_DRAIN) && i_last_out;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    state_nxt = ST_REQ;
                end
            end
            ST_REQ: begin
                state_nxt = ST_STREAM;
            end
            ST_STREAM: begin
                if (o_last) begin
                    state_nxt = ST_DRAIN;
                end
            end
            // wait for the tagged pixel to leave the datapath
            ST_DRAIN: begin
                if (i_last_out) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: rtl/pixel_counter.sv
`timescale 1ns/100ps
module pixel_counter (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_clr,
    input  logic                       i_en,
    input  logic [gray_pkg::CNT_W-1:0] i_npix,
    output logic                       o_term
);
    import gray_pkg::*;

    logic [CNT_W-1:0] count;

    // accepted pixels so far in this frame
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else if (i_clr) begin
            count <= '0;
        end else if (i_en) begin
            count <= count + 1'b1;
        end
    end

    // npix holds size minus one, so equal means final pixel
    assign o_term = (count == i_npix);

endmodule

// File: rtl/luma_threshold.sv
`timescale 1ns/100ps
module luma_threshold (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_accept,
    input  logic                        i_last,
    input  logic [gray_pkg::PIX_W-1:0]  i_red,
    input  logic [gray_pkg::PIX_W-1:0]  i_green,
    input  logic [gray_pkg::PIX_W-1:0]  i_blue,
    input  logic [gray_pkg::LUMA_W-1:0] i_thresh,
    input  logic                        i_binarize,
    output logic                        o_valid,
    output logic [gray_pkg::PIX_W-1:0]  o_gray,
    output logic                        o_bw,
    output logic                        o_last,
    output logic                        o_frame_start
);
    import gray_pkg::*;

    logic [LUMA_W-1:0] red_s1;
    logic [LUMA_W-1:0] green_s1;
    logic [LUMA_W-1:0] blue_s1;
    logic              valid_s1;
    logic              last_s1;
    logic [LUMA_W-1:0] luma;
    logic              dark;
    logic [PIX_W-1:0]  gray_nxt;
    logic              first_frame;

    // stage 1 weighted and shifted channels
    always_ff @(posedge i_clk) begin
        red_s1   <= LUMA_W'((i_red * W_RED) >> SH_RED);
        green_s1 <= LUMA_W'((i_green * W_GREEN) >> SH_GREEN);
        blue_s1  <= LUMA_W'((i_blue * W_BLUE) >> SH_BLUE);
    end

    // stage 2 sum, max 1049 fits in 11 bits
    assign luma = red_s1 + green_s1 + blue_s1;
    // not above threshold counts as dark
    assign dark = (luma <= i_thresh);

    always_comb begin
        if (i_binarize) begin
            gray_nxt = dark ? '0 : '1;
        end else if (luma > LUMA_W'({PIX_W{1'b1}})) begin
            gray_nxt = '1;
        end else begin
            gray_nxt = luma[PIX_W-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        o_gray <= gray_nxt;
        o_bw   <= dark;
    end

    // valid and last travel alongside the data
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_s1      <= 1'b0;
            last_s1       <= 1'b0;
            o_valid       <= 1'b0;
            o_last        <= 1'b0;
            o_frame_start <= 1'b0;
            first_frame   <= 1'b1;
        end else begin
            valid_s1      <= i_accept;
            last_s1       <= i_accept && i_last;
            o_valid       <= valid_s1;
            o_last        <= last_s1;
            // marks only the very first output after reset
            o_frame_start <= valid_s1 && first_frame;
            if (valid_s1) begin
                first_frame <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/gray_top.sv
`timescale 1ns/100ps
module gray_top (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  logic [gray_pkg::AXI_AW-1:0]   i_awaddr,
    input  logic                          i_wvalid,
    output logic                          o_wready,
    input  logic [gray_pkg::AXI_DW-1:0]   i_wdata,
    input  logic [gray_pkg::AXI_DW/8-1:0] i_wstrb,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    output logic [1:0]                    o_bresp,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    input  logic [gray_pkg::AXI_AW-1:0]   i_araddr,
    output logic                          o_rvalid,
    input  logic                          i_rready,
    output logic [gray_pkg::AXI_DW-1:0]   o_rdata,
    output logic [1:0]                    o_rresp,
    input  logic                          i_pix_valid,
    input  logic [gray_pkg::PIX_W-1:0]    i_red,
    input  logic [gray_pkg::PIX_W-1:0]    i_green,
    input  logic [gray_pkg::PIX_W-1:0]    i_blue,
    output logic                          o_read_req,
    output logic                          o_valid,
    output logic [gray_pkg::PIX_W-1:0]    o_gray,
    output logic                          o_bw,
    output logic                          o_frame_start
);
    import gray_pkg::*;

    logic              start;
    logic              binarize;
    logic [LUMA_W-1:0] thresh;
    logic [CNT_W-1:0]  npix;
    logic              busy;
    logic              done;
    logic              cnt_clr;
    logic              cnt_en;
    logic              term;
    logic              accept;
    logic              last_in;
    logic              last_out;

    // register block
    gray_csr csr0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
        .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
        .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
        .o_start(start), .o_binarize(binarize), .o_thresh(thresh), .o_npix(npix),
        .i_busy(busy), .i_done(done)
    );

    // frame sequencing
    frame_ctrl ctrl0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(start), .i_pix_valid(i_pix_valid),
        .i_term(term), .i_last_out(last_out),
        .o_cnt_clr(cnt_clr), .o_cnt_en(cnt_en), .o_accept(accept), .o_last(last_in),
        .o_read_req(o_read_req), .o_busy(busy), .o_done(done)
    );

    pixel_counter cnt0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_clr(cnt_clr), .i_en(cnt_en),
        .i_npix(npix), .o_term(term)
    );

    // luma datapath
    luma_threshold luma0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_accept(accept), .i_last(last_in),
        .i_red(i_red), .i_green(i_green), .i_blue(i_blue),
        .i_thresh(thresh), .i_binarize(binarize),
        .o_valid(o_valid), .o_gray(o_gray), .o_bw(o_bw), .o_last(last_out),
        .o_frame_start(o_frame_start)
    );

endmodule

// File: sim/gray_chk.sv
`timescale 1ns/100ps
module gray_chk (
    input logic i_clk,
    input logic i_rst,
    input logic i_pix_valid,
    input logic i_read_req,
    input logic i_valid,
    input logic i_frame_start
);
    import gray_pkg::*;

    // assertion failures so far
    int fail_count = 0;

    // request is a single cycle pulse
    read_req_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst) i_read_req |=> !i_read_req
    ) else begin
        $error("o_read_req stayed high for two cycles");
        fail_count++;
    end

    // every output pixel needs an input pixel one pipeline depth back
    valid_after_pixel: assert property (
        @(posedge i_clk) disable iff (i_rst) i_valid |-> $past(i_pix_valid, PIPE_DEPTH)
    ) else begin
        $error("o_valid without a pixel two cycles before");
        fail_count++;
    end

    frame_start_with_valid: assert property (
        @(posedge i_clk) disable iff (i_rst) i_frame_start |-> i_valid
    ) else begin
        $error("o_frame_start without o_valid");
        fail_count++;
    end

endmodule

// File: sim/tb_gray_top.sv
`timescale 1ns/100ps
module tb_gray_top;
    import gray_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_ROWS     = 5;

    typedef struct packed {
        logic [CNT_W-1:0]  npix;
        logic [LUMA_W-1:0] thresh;
        logic              binarize;
        logic [3:0]        gap;
        logic [PIX_W-1:0]  edge_val;
    } frame_t;

    // pixels, threshold, binarize, idle mask per pixel index mod 4, first pixel on all channels
    // 512 grey gives luma 526, so rows 2 and 3 sit on the threshold edge
    frame_t frames [N_ROWS] = '{
        '{20'd8,  11'd600, 1'b0, 4'b0000, 10'd1023},
        '{20'd13, 11'd600, 1'b0, 4'b1010, 10'd1023},
        '{20'd6,  11'd526, 1'b1, 4'b0110, 10'd512},
        '{20'd6,  11'd525, 1'b1, 4'b0001, 10'd512},
        '{20'd10, 11'd100, 1'b1, 4'b1111, 10'd0}
    };

    logic clk, rst;
    logic awvalid, wvalid, bready, arvalid, rready, pix_valid;
    logic [AXI_AW-1:0] awaddr, araddr;
    logic [AXI_DW-1:0] wdata, rdata;
    logic [AXI_DW/8-1:0] wstrb;
    logic [PIX_W-1:0] red, green, blue, gray;
    logic awready, wready, bvalid, arready, rvalid, read_req, valid, bw, frame_start;
    logic [1:0] bresp, rresp;

    int errors = 0;
    int checks = 0;
    int cyc = 0;
    int out_total = 0;
    int req_total = 0;
    logic [31:0] lcg_state = 32'd23;
    // expected {bw, gray} and the monitor cycle it must show up in
    logic [PIX_W:0] exp_px_q [$];
    int exp_cyc_q [$];

    gray_top dut0 (
        .i_clk(clk), .i_rst(rst),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
        .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
        .i_pix_valid(pix_valid), .i_red(red), .i_green(green), .i_blue(blue),
        .o_read_req(read_req), .o_valid(valid), .o_gray(gray), .o_bw(bw),
        .o_frame_start(frame_start)
    );

    bind gray_top gray_chk chk0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_pix_valid(i_pix_valid),
        .i_read_req(o_read_req), .i_valid(o_valid), .i_frame_start(o_frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [PIX_W-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[25:16];
    endfunction

    // each channel weighted and truncated on its own before the sum
    // returns {bw, gray}
    function automatic logic [PIX_W:0] expect_px(input logic [PIX_W-1:0] r, g, b,
                                                 input logic [LUMA_W-1:0] th, input logic bin);
        int luma;
        logic dark;
        luma = (int'(r) * 19) / 64 + (int'(g) * 75) / 128 + (int'(b) * 37) / 256;
        dark = (luma <= int'(th));
        if (bin) begin
            return {dark, dark ? 10'd0 : 10'd1023};
        end
        return {dark, (luma > 1023) ? 10'd1023 : PIX_W'(luma)};
    endfunction

    task automatic send_pixel(input logic [PIX_W-1:0] r, g, b, input logic taken,
                              input frame_t f);
        @(posedge clk);
        pix_valid <= 1'b1;
        red       <= r;
        green     <= g;
        blue      <= b;
        // input seen at the next negedge, output PIPE_DEPTH negedges after that
        if (taken) begin
            exp_px_q.push_back(expect_px(r, g, b, f.thresh, f.binarize));
            exp_cyc_q.push_back(cyc + 1 + PIPE_DEPTH);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             input int hold);
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= '1;
        do @(negedge clk); while (!awready);
        check_val("o_wready", wready, 1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        check_val("o_bvalid", bvalid, 1);
        // bready low, response has to stay put
        repeat (hold) begin
            @(negedge clk);
            check_val("o_bvalid", bvalid, 1);
            check_val("o_bresp", bresp, RESP_OKAY);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_val("o_bvalid", bvalid, 0);
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, input int hold,
                            output logic [AXI_DW-1:0] data);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        check_val("o_rvalid", rvalid, 1);
        check_val("o_rresp", rresp, RESP_OKAY);
        data = rdata;
        repeat (hold) begin
            @(negedge clk);
            check_val("o_rvalid", rvalid, 1);
            check_val("o_rdata", rdata, data);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_val("o_rvalid", rvalid, 0);
    endtask

    // output monitor, also counts read request cycles
    always @(negedge clk) begin : out_monitor
        logic [PIX_W:0] e;
        int ecyc;
        cyc = cyc + 1;
        if (!rst && read_req) begin
            req_total++;
        end
        if (!rst && valid) begin
            if (exp_px_q.size() == 0) begin
                errors++;
                $display("Error: output pixel appeared with no accepted pixel pending at %0t",
                         $time);
            end else begin
                e    = exp_px_q.pop_front();
                ecyc = exp_cyc_q.pop_front();
                check_val("o_gray", gray, e[PIX_W-1:0]);
                check_val("o_bw", bw, e[PIX_W]);
                check_val("o_valid cycle", cyc, ecyc);
                check_val("o_frame_start", frame_start, out_total == 0);
            end
            out_total++;
        end
    end

    // limit grows with the frame sizes in the table
    initial begin : watchdog
        longint limit;
        limit = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            limit += longint'(frames[r].npix) * 4 + 200;
        end
        #(limit * CLK_PERIOD);
        $display("Error: run timed out after %0d cycles without finishing", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main_seq
        logic [AXI_DW-1:0] rd;
        frame_t f;
        int req_before;
        int out_before;
        int fails;
        rst = 1'b1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        pix_valid = 1'b0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = '0;
        red = '0;
        green = '0;
        blue = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("o_read_req", read_req, 0);
        check_val("o_valid", valid, 0);
        check_val("o_frame_start", frame_start, 0);
        check_val("o_bvalid", bvalid, 0);
        check_val("o_rvalid", rvalid, 0);
        check_val("o_awready", awready, 0);
        check_val("o_wready", wready, 0);
        check_val("o_arready", arready, 0);
        // reset values of the register map
        axi_read(ADDR_THRESH, 0, rd);
        check_val("THRESH", rd, 32'd600);
        axi_read(ADDR_NPIX, 0, rd);
        check_val("NPIX", rd, 32'd307199);
        axi_read(ADDR_CTRL, 0, rd);
        check_val("CTRL", rd, 32'h0);
        axi_read(ADDR_STATUS, 0, rd);
        check_val("STATUS", rd, 32'h0);

        for (int r = 0; r < N_ROWS; r++) begin
            f = frames[r];
            axi_write(ADDR_THRESH, AXI_DW'(f.thresh), r);
            axi_read(ADDR_THRESH, r, rd);
            check_val("THRESH", rd, AXI_DW'(f.thresh));
            axi_write(ADDR_NPIX, AXI_DW'(f.npix - 1), 0);
            // controller idle, these go nowhere
            repeat (3) send_pixel(lcg_next(), lcg_next(), lcg_next(), 1'b0, f);
            idle_cycle();
            req_before = req_total;
            out_before = out_total;
            axi_write(ADDR_CTRL, AXI_DW'({f.binarize, 1'b1}), 0);
            axi_read(ADDR_STATUS, 0, rd);
            check_val("STATUS after start", rd, 32'h1);
            axi_read(ADDR_CTRL, 0, rd);
            check_val("CTRL", rd, AXI_DW'({f.binarize, 1'b0}));
            for (int i = 0; i < int'(f.npix); i++) begin
                if (f.gap[i % 4]) begin
                    idle_cycle();
                end
                if (i == 0) begin
                    send_pixel(f.edge_val, f.edge_val, f.edge_val, 1'b1, f);
                end else begin
                    send_pixel(lcg_next(), lcg_next(), lcg_next(), 1'b1, f);
                end
            end
            // past the last pixel, also dropped
            repeat (3) send_pixel(lcg_next(), lcg_next(), lcg_next(), 1'b0, f);
            idle_cycle();
            rd = '0;
            while (!rd[1]) begin
                axi_read(ADDR_STATUS, 0, rd);
            end
            check_val("STATUS at frame end", rd, 32'h2);
            check_val("o_read_req pulses", req_total - req_before, 1);
            check_val("o_valid count", out_total - out_before, f.npix);
            check_val("pending pixels", exp_px_q.size(), 0);
        end

        fails = dut0.chk0.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/gray_pkg.sv
rtl/gray_csr.sv
rtl/frame_ctrl.sv
rtl/pixel_counter.sv
rtl/luma_threshold.sv
rtl/gray_top.sv
sim/gray_chk.sv
sim/tb_gray_top.sv
